//--- hw/debug_cmd_pkg.sv
package debug_cmd_pkg;

    // uart byte width
    localparam int NB_BYTE = 8;

    // command codes as sent by the host
    typedef enum logic [NB_BYTE-1:0] {
        CMD_WRITE_IM  = 8'd1,
        CMD_START     = 8'd2,
        CMD_STEP_MODE = 8'd3,
        CMD_STEP      = 8'd7,
        CMD_CONTINUE  = 8'd8
    } debug_cmd_e;

    // controller states, visible on o_state
    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,
        ST_LOAD      = 4'd1,
        ST_READY     = 4'd2,
        ST_RUN       = 4'd3,
        ST_STEP_WAIT = 4'd4,
        ST_DUMP      = 4'd5
    } debug_state_e;

    // one received byte, two readings
    // cmd while waiting for a command, raw while loading a program
    typedef union packed {
        debug_cmd_e         cmd;
        logic [NB_BYTE-1:0] raw;
    } rx_byte_u;

endpackage

//--- hw/debug_bus_pkg.sv
package debug_bus_pkg;

    // pc and register width
    localparam int NB_WORD        = 32;
    localparam int BYTES_PER_WORD = 4;
    // im address as seen by the datapath
    localparam int NB_IM_ADDR     = 32;

    // instruction memory write port
    typedef struct packed {
        logic                                write;
        logic [NB_IM_ADDR-1:0]               addr;
        logic [debug_cmd_pkg::NB_BYTE-1:0]   data;
    } im_write_t;

    // datapath run controls
    typedef struct packed {
        logic enable;
        logic step_mode;
        logic step;
        logic rb_read;
    } dp_ctrl_t;

    // byte offered to the uart transmitter
    typedef struct packed {
        logic                              start;
        logic [debug_cmd_pkg::NB_BYTE-1:0] data;
    } tx_req_t;

endpackage

//--- hw/command_fsm.sv
`timescale 1ns/1ps

module command_fsm (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx_done,
    input  debug_cmd_pkg::rx_byte_u     i_rx_data,
    input  logic                        i_hlt,
    input  logic                        i_load_done,
    input  logic                        i_dump_done,
    output logic                        o_load_start,
    output logic                        o_dump_start,
    output debug_bus_pkg::dp_ctrl_t     o_dp,
    output debug_cmd_pkg::debug_state_e o_state
);

    import debug_cmd_pkg::*;

    debug_state_e state;
    debug_state_e next_state;
    // registered so it lines up with the first dump cycle
    logic         step_q;
    logic         step_cmd;

    // step request accepted only while waiting in step mode
    assign step_cmd = (state == ST_STEP_WAIT) && !i_hlt && i_rx_done &&
                      (i_rx_data.cmd == CMD_STEP);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state  <= ST_IDLE;
            step_q <= 1'b0;
        end else begin
            state  <= next_state;
            step_q <= step_cmd;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                // only the write command applies here
                if (i_rx_done && i_rx_data.cmd == CMD_WRITE_IM) begin
                    next_state = ST_LOAD;
                end
            end
            ST_LOAD: begin
                // bytes belong to the loader now
                if (i_load_done) begin
                    next_state = ST_READY;
                end
            end
            ST_READY: begin
                if (i_rx_done) begin
                    case (i_rx_data.cmd)
                        CMD_START:     next_state = ST_RUN;
                        CMD_STEP_MODE: next_state = ST_STEP_WAIT;
                        default:       next_state = ST_READY;
                    endcase
                end
            end
            ST_RUN: begin
                if (i_hlt) begin
                    next_state = ST_IDLE;
                end
            end
            ST_STEP_WAIT: begin
                // halt wins over any command in the same cycle
                if (i_hlt) begin
                    next_state = ST_IDLE;
                end else if (i_rx_done) begin
                    case (i_rx_data.cmd)
                        CMD_STEP:     next_state = ST_DUMP;
                        CMD_CONTINUE: next_state = ST_RUN;
                        default:      next_state = ST_STEP_WAIT;
                    endcase
                end
            end
            ST_DUMP: begin
                if (i_dump_done) begin
                    next_state = ST_STEP_WAIT;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // loader arms on the command cycle, ready for the very next byte
    assign o_load_start = (state == ST_IDLE) && i_rx_done && (i_rx_data.cmd == CMD_WRITE_IM);
    // dump kicks off together with the step pulse
    assign o_dump_start = step_q;

    always_comb begin
        o_dp           = '0;
        o_dp.enable    = (state == ST_RUN) || (state == ST_STEP_WAIT);
        o_dp.step_mode = (state == ST_STEP_WAIT) || (state == ST_DUMP);
        o_dp.step      = step_q;
        // rb_read comes from the dumper, merged at the top
        o_dp.rb_read   = 1'b0;
    end

    assign o_state = state;

    // a step pulse never shows up outside step mode
    a_step_in_step_mode : assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_dp.step |-> o_dp.step_mode
    ) else $error("step pulse outside step mode");

endmodule

//--- hw/program_loader.sv
`timescale 1ns/1ps

module program_loader #(
    parameter int IM_DEPTH = 256
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_load_start,
    input  logic                     i_rx_done,
    input  debug_cmd_pkg::rx_byte_u  i_rx_data,
    output debug_bus_pkg::im_write_t o_im,
    output logic                     o_load_done
);

    import debug_bus_pkg::*;

    localparam int NB_IM_CNT = $clog2(IM_DEPTH);

    logic                 armed;
    logic [NB_IM_CNT-1:0] byte_cnt;
    logic [NB_IM_CNT-1:0] wr_addr;
    logic                 wr_q;
    logic                 done_q;
    logic [7:0]           wr_data;
    logic                 last_byte;

    assign last_byte = (byte_cnt == NB_IM_CNT'(IM_DEPTH - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            armed    <= 1'b0;
            byte_cnt <= '0;
            wr_addr  <= '0;
            wr_q     <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            // strobes last one cycle
            wr_q   <= 1'b0;
            done_q <= 1'b0;
            if (i_load_start) begin
                armed    <= 1'b1;
                byte_cnt <= '0;
            end else if (armed && i_rx_done) begin
                wr_q     <= 1'b1;
                wr_addr  <= byte_cnt;
                byte_cnt <= byte_cnt + 1'b1;
                // done rides with the last write strobe
                if (last_byte) begin
                    armed  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // program byte, raw view of the union
    always_ff @(posedge i_clock) begin
        if (armed && i_rx_done) begin
            wr_data <= i_rx_data.raw;
        end
    end

    assign o_im.write  = wr_q;
    assign o_im.addr   = NB_IM_ADDR'(wr_addr);
    assign o_im.data   = wr_data;
    assign o_load_done = done_q;

    a_write_in_range : assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_im.write |-> (o_im.addr < NB_IM_ADDR'(IM_DEPTH))
    ) else $error("instruction memory write beyond IM_DEPTH");

endmodule

//--- hw/state_dumper.sv
`timescale 1ns/1ps

module state_dumper #(
    parameter int RB_DEPTH = 32
) (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic                                i_dump_start,
    input  logic                                i_tx_done,
    input  logic [debug_bus_pkg::NB_WORD-1:0]   i_pc_value,
    input  logic [debug_bus_pkg::NB_WORD-1:0]   i_br_data,
    output debug_bus_pkg::tx_req_t              o_tx,
    output logic [$clog2(RB_DEPTH)-1:0]         o_rb_addr,
    output logic                                o_rb_read,
    output logic                                o_dump_done
);

    import debug_cmd_pkg::*;
    import debug_bus_pkg::*;

    localparam int NB_BYTE_CNT = $clog2(BYTES_PER_WORD);
    localparam int NB_RB_ADDR  = $clog2(RB_DEPTH);
    // word 0 is the pc, words 1..RB_DEPTH are registers
    localparam int NB_WORD_CNT = $clog2(RB_DEPTH + 1);

    typedef enum logic [1:0] {
        D_IDLE,
        D_LOAD,
        D_SEND
    } dump_phase_e;

    dump_phase_e            phase;
    logic [NB_BYTE_CNT-1:0] byte_cnt;
    logic [NB_WORD_CNT-1:0] word_cnt;
    logic [NB_RB_ADDR-1:0]  rb_addr;
    logic                   tx_start;
    logic                   done_q;
    logic [NB_WORD-1:0]     word_q;
    logic                   last_byte;
    logic                   last_word;

    assign last_byte = (byte_cnt == NB_BYTE_CNT'(BYTES_PER_WORD - 1));
    assign last_word = (word_cnt == NB_WORD_CNT'(RB_DEPTH));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase    <= D_IDLE;
            byte_cnt <= '0;
            word_cnt <= '0;
            rb_addr  <= '0;
            tx_start <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (phase)
                D_IDLE: begin
                    if (i_dump_start) begin
                        phase    <= D_LOAD;
                        word_cnt <= '0;
                    end
                end
                D_LOAD: begin
                    // word latched this cycle, start offering it
                    phase    <= D_SEND;
                    byte_cnt <= '0;
                    tx_start <= 1'b1;
                    // next word reads register word_cnt
                    // address held for the whole send
                    rb_addr  <= word_cnt[NB_RB_ADDR-1:0];
                end
                D_SEND: begin
                    // hold the byte until the transmitter takes it
                    if (i_tx_done) begin
                        if (last_byte) begin
                            tx_start <= 1'b0;
                            if (last_word) begin
                                phase  <= D_IDLE;
                                done_q <= 1'b1;
                            end else begin
                                phase    <= D_LOAD;
                                word_cnt <= word_cnt + 1'b1;
                            end
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: phase <= D_IDLE;
            endcase
        end
    end

    // word latch, shifted left so the top byte is always the one on offer
    always_ff @(posedge i_clock) begin
        if (phase == D_LOAD) begin
            word_q <= (word_cnt == '0) ? i_pc_value : i_br_data;
        end else if (phase == D_SEND && i_tx_done) begin
            word_q <= word_q << NB_BYTE;
        end
    end

    assign o_tx.start  = tx_start;
    assign o_tx.data   = word_q[NB_WORD-1 -: NB_BYTE];
    assign o_rb_addr   = rb_addr;
    // debug read port busy for the whole dump
    assign o_rb_read   = (phase != D_IDLE);
    assign o_dump_done = done_q;

    // a byte is never withdrawn before the transmitter took it
    a_start_held : assert property (
        @(posedge i_clock) disable iff (i_reset)
        $fell(o_tx.start) |-> $past(i_tx_done)
    ) else $error("tx start dropped without tx done");

endmodule

//--- hw/debug_unit.sv
`timescale 1ns/1ps

module debug_unit #(
    parameter int IM_DEPTH = 256,
    parameter int RB_DEPTH = 32
) (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic                                i_rx_done,
    input  debug_cmd_pkg::rx_byte_u             i_rx_data,
    input  logic                                i_tx_done,
    input  logic                                i_hlt,
    input  logic [debug_bus_pkg::NB_WORD-1:0]   i_pc_value,
    input  logic [debug_bus_pkg::NB_WORD-1:0]   i_br_data,
    output debug_bus_pkg::im_write_t            o_im,
    output debug_bus_pkg::dp_ctrl_t             o_dp,
    output debug_bus_pkg::tx_req_t              o_tx,
    output logic [$clog2(RB_DEPTH)-1:0]         o_rb_addr,
    output debug_cmd_pkg::debug_state_e         o_state
);

    import debug_bus_pkg::*;

    // handshakes between the controller and its helpers
    logic     load_start;
    logic     load_done;
    logic     dump_start;
    logic     dump_done;
    logic     rb_read;
    dp_ctrl_t fsm_dp;

    command_fsm u_command_fsm (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .i_hlt        (i_hlt),
        .i_load_done  (load_done),
        .i_dump_done  (dump_done),
        .o_load_start (load_start),
        .o_dump_start (dump_start),
        .o_dp         (fsm_dp),
        .o_state      (o_state)
    );

    program_loader #(
        .IM_DEPTH (IM_DEPTH)
    ) u_program_loader (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_load_start (load_start),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .o_im         (o_im),
        .o_load_done  (load_done)
    );

    state_dumper #(
        .RB_DEPTH (RB_DEPTH)
    ) u_state_dumper (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_dump_start (dump_start),
        .i_tx_done    (i_tx_done),
        .i_pc_value   (i_pc_value),
        .i_br_data    (i_br_data),
        .o_tx         (o_tx),
        .o_rb_addr    (o_rb_addr),
        .o_rb_read    (rb_read),
        .o_dump_done  (dump_done)
    );

    // run controls from the fsm, register read enable from the dumper
    assign o_dp = '{
        enable    : fsm_dp.enable,
        step_mode : fsm_dp.step_mode,
        step      : fsm_dp.step,
        rb_read   : rb_read
    };

endmodule

//--- verification/debug_checker.sv
`timescale 1ns/1ps

module debug_checker #(
    parameter int RB_DEPTH = 4
) (
    input  logic                                i_clock,
    input  logic                                i_reset,
    input  logic                                i_rx_done,
    input  debug_cmd_pkg::rx_byte_u             i_rx_data,
    input  logic                                i_tx_done,
    input  logic [debug_bus_pkg::NB_WORD-1:0]   i_pc_value,
    input  debug_bus_pkg::im_write_t            i_im,
    input  debug_bus_pkg::dp_ctrl_t             i_dp,
    input  debug_bus_pkg::tx_req_t              i_tx,
    input  debug_cmd_pkg::debug_state_e         i_state,
    input  logic [7:0]                          i_test_name,
    input  logic                                i_check_state,
    input  debug_cmd_pkg::debug_state_e         i_exp_state,
    output int                                  o_value_errors,
    output int                                  o_other_errors
);

    import debug_cmd_pkg::*;
    import debug_bus_pkg::*;

    // program bytes seen on the rx side, not yet written
    logic [7:0]   im_queue[$];
    // bytes the current dump still owes the transmitter
    logic [7:0]   tx_queue[$];
    int           exp_addr;
    debug_state_e prev_state;
    logic         prev_write;
    logic         prev_step;
    // a program byte arrived last cycle
    logic         prev_load_rx;
    logic         exp_enable;
    logic         exp_step_mode;

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        begin
            o_value_errors++;
            $display("Fail test %02h, %s: expected %0h, actual %0h",
                     i_test_name, what, exp_val, act_val);
        end
    endtask

    task automatic report_problem(input string msg);
        begin
            o_other_errors++;
            $display("test %02h: %s", i_test_name, msg);
        end
    endtask

    // pc first, then each register, top byte first
    task automatic expect_dump();
        logic [NB_WORD-1:0] word;
        begin
            for (int w = 0; w <= RB_DEPTH; w++) begin
                if (w == 0) begin
                    word = i_pc_value;
                end else begin
                    // register model answers with its index byte, top bit set
                    word = {4{8'h80 | 8'(w - 1)}};
                end
                for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
                    tx_queue.push_back(word[b*8 +: 8]);
                end
            end
        end
    endtask

    initial begin
        o_value_errors = 0;
        o_other_errors = 0;
        exp_addr       = 0;
        prev_state     = ST_IDLE;
        prev_write     = 1'b0;
        prev_step      = 1'b0;
        prev_load_rx   = 1'b0;
    end

    // everything sampled mid cycle, well away from both edges
    always @(negedge i_clock) begin
        if (i_reset) begin
            if (i_state !== ST_IDLE || i_im.write !== 1'b0 || i_dp.enable !== 1'b0 ||
                i_dp.step !== 1'b0 || i_tx.start !== 1'b0 ||
                i_dp.step_mode !== 1'b0 || i_dp.rb_read !== 1'b0) begin
                report_problem("outputs not idle while reset is held");
            end
            im_queue.delete();
            tx_queue.delete();
            exp_addr = 0;
        end else begin
            // new load restarts at address 0
            if (prev_state == ST_IDLE && i_state == ST_LOAD) begin
                exp_addr = 0;
            end
            if (prev_load_rx && i_im.write !== 1'b1) begin
                report_problem("no memory write in the cycle after a program byte");
            end
            if (i_im.write) begin
                if (prev_write) begin
                    report_problem("write strobe held longer than one cycle");
                end
                if (im_queue.size() == 0) begin
                    report_problem("memory write with no program byte received");
                end else begin
                    if (i_im.data !== im_queue[0]) begin
                        report_mismatch("program byte", 32'(im_queue[0]), 32'(i_im.data));
                    end
                    void'(im_queue.pop_front());
                end
                if (i_im.addr !== 32'(exp_addr)) begin
                    report_mismatch("write address", 32'(exp_addr), i_im.addr);
                end
                exp_addr++;
            end
            if (i_rx_done && i_state == ST_LOAD) begin
                im_queue.push_back(i_rx_data.raw);
            end

            // datapath enable only in run and step_wait
            exp_enable = (i_state == ST_RUN) || (i_state == ST_STEP_WAIT);
            if (i_dp.enable !== exp_enable) begin
                report_mismatch("datapath enable", 32'(exp_enable), 32'(i_dp.enable));
            end
            // step mode held while waiting and through the dump
            exp_step_mode = (i_state == ST_STEP_WAIT) || (i_state == ST_DUMP);
            if (i_dp.step_mode !== exp_step_mode) begin
                report_mismatch("step mode", 32'(exp_step_mode), 32'(i_dp.step_mode));
            end
            // register bank read only on behalf of a dump
            if (i_tx.start && i_dp.rb_read !== 1'b1) begin
                report_mismatch("register read during dump", 32'd1, 32'(i_dp.rb_read));
            end
            if (i_state != ST_DUMP && i_dp.rb_read !== 1'b0) begin
                report_mismatch("register read outside dump", 32'd0, 32'(i_dp.rb_read));
            end

            if (i_dp.step) begin
                if (prev_step) begin
                    report_problem("step pulse longer than one cycle");
                end
                if (i_state !== ST_DUMP) begin
                    report_mismatch("state at step", 32'(ST_DUMP), 32'(i_state));
                end
                if (tx_queue.size() != 0) begin
                    report_problem("step arrived before the previous dump finished");
                end
                expect_dump();
            end

            // one transfer per cycle with start and done both high
            if (i_tx.start && i_tx_done) begin
                if (tx_queue.size() == 0) begin
                    report_problem("byte transmitted outside a dump");
                end else begin
                    if (i_tx.data !== tx_queue[0]) begin
                        report_mismatch("dump byte", 32'(tx_queue[0]), 32'(i_tx.data));
                    end
                    void'(tx_queue.pop_front());
                end
            end
            if (prev_state == ST_DUMP && i_state != ST_DUMP && tx_queue.size() != 0) begin
                report_problem($sformatf("dump ended with %0d bytes missing",
                                         tx_queue.size()));
                tx_queue.delete();
            end

            if (i_check_state && i_state !== i_exp_state) begin
                report_mismatch("end state", 32'(i_exp_state), 32'(i_state));
            end
        end
        prev_state   = i_state;
        prev_write   = i_im.write;
        prev_step    = i_dp.step;
        prev_load_rx = !i_reset && i_rx_done && (i_state == ST_LOAD);
    end

endmodule

//--- verification/tb_debug_unit.sv
`timescale 1ns/1ps

module tb_debug_unit;

    import debug_cmd_pkg::*;
    import debug_bus_pkg::*;

    localparam int IM_DEPTH  = 8;
    localparam int RB_DEPTH  = 4;
    localparam int NUM_TESTS = 9;
    // name, count, ten byte slots, pc, end state, halt flag
    localparam int REC_WORDS = 15;

    logic               i_clock;
    logic               reset;
    logic               rx_done;
    rx_byte_u           rx_data;
    logic               tx_done;
    logic               hlt;
    logic [NB_WORD-1:0] pc_value;
    logic [NB_WORD-1:0] br_data;
    im_write_t          im;
    dp_ctrl_t           dp;
    tx_req_t            tx;
    logic [1:0]         rb_addr;
    debug_state_e       state;

    logic [31:0]        test_mem [0:NUM_TESTS*REC_WORDS-1];
    integer             seed;
    int                 cycles;
    int                 cycle_limit;
    logic [7:0]         test_name;
    logic               check_state;
    debug_state_e       exp_state;
    int                 value_errors;
    int                 other_errors;

    debug_unit #(
        .IM_DEPTH (IM_DEPTH),
        .RB_DEPTH (RB_DEPTH)
    ) u_debug_unit (
        .i_clock    (i_clock),
        .i_reset    (reset),
        .i_rx_done  (rx_done),
        .i_rx_data  (rx_data),
        .i_tx_done  (tx_done),
        .i_hlt      (hlt),
        .i_pc_value (pc_value),
        .i_br_data  (br_data),
        .o_im       (im),
        .o_dp       (dp),
        .o_tx       (tx),
        .o_rb_addr  (rb_addr),
        .o_state    (state)
    );

    debug_checker #(
        .RB_DEPTH (RB_DEPTH)
    ) u_debug_checker (
        .i_clock        (i_clock),
        .i_reset        (reset),
        .i_rx_done      (rx_done),
        .i_rx_data      (rx_data),
        .i_tx_done      (tx_done),
        .i_pc_value     (pc_value),
        .i_im           (im),
        .i_dp           (dp),
        .i_tx           (tx),
        .i_state        (state),
        .i_test_name    (test_name),
        .i_check_state  (check_state),
        .i_exp_state    (exp_state),
        .o_value_errors (value_errors),
        .o_other_errors (other_errors)
    );

    initial begin
        i_clock = 1'b0;
        forever #4 i_clock = ~i_clock;
    end

    // register bank, one cycle read latency
    always @(posedge i_clock) begin
        #1;
        br_data = {4{8'h80 | 8'(rb_addr)}};
    end

    // uart transmitter, takes each offered byte after 1 to 6 cycles
    initial begin
        int delay;
        forever begin
            @(posedge i_clock);
            #1;
            if (tx.start) begin
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay - 1) begin
                    @(posedge i_clock);
                    #1;
                end
                tx_done = 1'b1;
                @(posedge i_clock);
                #1;
                tx_done = 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge i_clock);
            cycles++;
        end
        $display("timeout after %0d cycles, a test never finished", cycles);
        $display("tests failed");
        $finish;
    end

    // one rx_done pulse after a random idle gap
    task automatic send_byte(input logic [7:0] value);
        int gap;
        begin
            gap = 1 + ($unsigned($random(seed)) % 4);
            repeat (gap) @(posedge i_clock);
            #1;
            rx_done     = 1'b1;
            rx_data.raw = value;
            @(posedge i_clock);
            #1;
            rx_done     = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        int base;
        int count;
        begin
            base      = t * REC_WORDS;
            count     = test_mem[base+1];
            test_name = test_mem[base][7:0];
            pc_value  = test_mem[base+12];
            exp_state = debug_state_e'(test_mem[base+13][3:0]);
            for (int i = 0; i < count; i++) begin
                send_byte(test_mem[base+2+i][7:0]);
            end
            // a step leaves a dump running, wait for it to drain
            while (state == ST_DUMP) @(negedge i_clock);
            if (test_mem[base+14][0]) begin
                repeat (3) @(posedge i_clock);
                #1;
                hlt = 1'b1;
                @(posedge i_clock);
                #1;
                hlt = 1'b0;
            end
            @(posedge i_clock);
            #1;
            check_state = 1'b1;
            @(posedge i_clock);
            #1;
            check_state = 1'b0;
        end
    endtask

    initial begin
        int total_bytes;
        int dumps;
        int base;
        reset       = 1'b1;
        rx_done     = 1'b0;
        rx_data     = '0;
        tx_done     = 1'b0;
        hlt         = 1'b0;
        pc_value    = '0;
        br_data     = '0;
        test_name   = '0;
        check_state = 1'b0;
        exp_state   = ST_IDLE;
        seed        = 64954;
        cycle_limit = 0;
        total_bytes = 0;
        dumps       = 0;
        $readmemh("verification/debug_input.txt", test_mem);
        for (int t = 0; t < NUM_TESTS; t++) begin
            base         = t * REC_WORDS;
            total_bytes += test_mem[base+1];
            // a step that ends in step_wait produced a dump
            if (test_mem[base+13] == 32'd4 &&
                test_mem[base+1+test_mem[base+1]] == 32'h07) begin
                dumps++;
            end
        end
        cycle_limit = total_bytes * 10 + dumps * 18 * 8 + 200;

        repeat (16) @(posedge i_clock);
        #1;
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        repeat (5) @(posedge i_clock);
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verification/debug_input.txt
// name count b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 pc state halt
// unused byte slots are zero, state 0 idle 2 ready 4 step_wait
00 2 02 07 00 00 00 00 00 00 00 00 00000000 0 0
01 9 01 13 a5 5a 07 08 ff 00 3c 00 00000000 2 0
02 3 05 07 08 00 00 00 00 00 00 00 00000000 2 0
03 1 02 00 00 00 00 00 00 00 00 00 00000000 0 1
04 9 01 81 42 c3 24 e5 66 07 99 00 00000000 2 0
05 2 03 09 00 00 00 00 00 00 00 00 00000000 4 0
06 1 07 00 00 00 00 00 00 00 00 00 00400010 4 0
07 1 07 00 00 00 00 00 00 00 00 00 deadbeef 4 0
08 1 08 00 00 00 00 00 00 00 00 00 00000000 0 1

//--- sim.f
hw/debug_cmd_pkg.sv
hw/debug_bus_pkg.sv
hw/command_fsm.sv
hw/program_loader.sv
hw/state_dumper.sv
hw/debug_unit.sv
verification/debug_checker.sv
verification/tb_debug_unit.sv

//--- Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tb_debug_unit
OBJ_DIR   ?= obj_dir
FILE_LIST ?= sim.f
PASS_TEXT ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
